/* source/vec_alu_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VLEN must be a multiple of 32. NUM_ALU from 1 to 4.
// RS_DEPTH must be a power of two, at least NUM_ALU.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VEC_ALU_PARAMS_SVH
`define VEC_ALU_PARAMS_SVH

// vector register width in bits
`define VLEN 128

// ALU lanes fed from one station
`define NUM_ALU 2

// station entries
`define RS_DEPTH 8

// ROB tag bits
`define ROB_TAG_W 4

`endif

/* source/vec_alu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the vector ALU cluster.
// Operand order follows RVV, vd = vs2 op vs1.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "vec_alu_params.svh"

package vec_alu_pkg;

  // full 3-bit space is used, no spare code
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_SLL = 3'd2,
    ALU_SRL = 3'd3,
    ALU_SRA = 3'd4,
    ALU_AND = 3'd5,
    ALU_OR  = 3'd6,
    ALU_XOR = 3'd7
  } alu_op_e;

  // 2'd3 is not a legal element width
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  // one vector register, viewed per sew
  typedef union packed {
    logic [`VLEN/8-1:0][7:0]   b;
    logic [`VLEN/16-1:0][15:0] h;
    logic [`VLEN/32-1:0][31:0] w;
  } vreg_u;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    alu_op_e               op;
    sew_e                  sew;
    vreg_u                 vs2;
    vreg_u                 vs1;
  } alu_uop_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    vreg_u                 data;
  } alu_result_t;

endpackage

/* source/vec_alu_rs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular buffer with one push and up to NUM_ALU pops per cycle.
// A push while full is dropped. Pops must be contiguous
// from lane 0 and never exceed the entry count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_rs
  import vec_alu_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           push,
  input  alu_uop_t                       push_uop,
  input  logic     [`NUM_ALU-1:0]        pop,
  output logic                           full,
  output logic                           rs_empty,
  output logic     [`NUM_ALU-1:1]        rs_almost_empty,
  output alu_uop_t [`NUM_ALU-1:0]        lane_uop
);

  localparam int PTR_W = $clog2(`RS_DEPTH);
  localparam int CNT_W = $clog2(`RS_DEPTH + 1);
  localparam int POP_W = $clog2(`NUM_ALU + 1);

  // entry storage
  alu_uop_t             mem [`RS_DEPTH];
  logic     [PTR_W-1:0] head;
  logic     [PTR_W-1:0] tail;
  logic     [CNT_W-1:0] count;
  logic     [POP_W-1:0] pop_cnt;
  logic                 push_ok;

  // drop the push when no room
  assign push_ok = push && !full;

  // number of lanes retiring this cycle
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < `NUM_ALU; i++) begin
      pop_cnt = pop_cnt + POP_W'(pop[i]);
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push_ok) begin
        tail <= tail + 1'b1;
      end
      // head skips every popped entry at once
      head  <= head + PTR_W'(pop_cnt);
      count <= count + CNT_W'(push_ok) - CNT_W'(pop_cnt);
    end
  end

  // entry payload written at tail
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[tail] <= push_uop;
    end
  end

  assign full     = (count == CNT_W'(`RS_DEPTH));
  assign rs_empty = (count == '0);

  // bit i high when lane i has nothing to read
  for (genvar i = 1; i < `NUM_ALU; i++) begin : g_aempty
    assign rs_almost_empty[i] = (count <= CNT_W'(i));
  end

  // lane i reads head + i modulo depth
  for (genvar i = 0; i < `NUM_ALU; i++) begin : g_rd
    logic [PTR_W-1:0] rd_idx;
    assign rd_idx      = head + PTR_W'(i);
    assign lane_uop[i] = mem[rd_idx];
  end

  // dispatch must watch full
  a_no_push_full : assert property (@(posedge clk) disable iff (rst)
    !(push && full))
    else $error("push while station full");

  // popped lanes form a run from lane 0
  a_pop_contig : assert property (@(posedge clk) disable iff (rst)
    ((pop & (pop + 1'b1)) == '0))
    else $error("pop vector not contiguous");

  // cannot retire entries the station does not hold
  a_pop_le_count : assert property (@(posedge clk) disable iff (rst)
    (CNT_W'(pop_cnt) <= count))
    else $error("pop exceeds entry count");

endmodule

/* source/vec_alu_addsub.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Element-wise add and subtract on 8-bit slices.
// Carries stay inside one element; results wrap, no saturation.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_addsub
  import vec_alu_pkg::*;
(
  input  logic  is_sub,
  input  sew_e  sew,
  input  vreg_u a,
  input  vreg_u b,
  output vreg_u sum
);

  localparam int NB = `VLEN / 8;

  // second operand after optional inversion
  vreg_u                b_op;
  // carry[k] enters byte k from byte k-1
  logic  [NB:0]         carry;
  logic  [NB-1:0][7:0]  byte_sum;

  // two's complement, invert here and add one below
  assign b_op     = is_sub ? ~b : b;
  assign carry[0] = 1'b0;

  for (genvar k = 0; k < NB; k++) begin : g_byte
    logic elem_lo;
    logic cin;

    // is byte k the lowest byte of its element
    always_comb begin
      case (sew)
        SEW_16:  elem_lo = (k % 2 == 0);
        SEW_32:  elem_lo = (k % 4 == 0);
        default: elem_lo = 1'b1;
      endcase
    end

    // element start takes the subtract one,
    // upper bytes take the ripple carry
    assign cin = elem_lo ? is_sub : carry[k];

    // 8-bit slice, carry out on bit 8
    assign {carry[k+1], byte_sum[k]} = {1'b0, a.b[k]} + {1'b0, b_op.b[k]} + {8'd0, cin};
  end

  // top carry of each element is dropped
  assign sum.b = byte_sum;

endmodule

/* source/vec_alu_shift.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Element shifts sll, srl, sra.
// Amount is the low log2(sew) bits of each vs1 element.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_shift
  import vec_alu_pkg::*;
(
  input  alu_op_e op,
  input  sew_e    sew,
  input  vreg_u   a,
  input  vreg_u   amt,
  output vreg_u   res
);

  localparam int NB = `VLEN / 8;
  localparam int NH = `VLEN / 16;
  localparam int NW = `VLEN / 32;

  logic                 is_sra;
  logic [NB-1:0][7:0]   sl8;
  logic [NB-1:0][7:0]   sr8;
  logic [NH-1:0][15:0]  sl16;
  logic [NH-1:0][15:0]  sr16;
  logic [NW-1:0][31:0]  sl32;
  logic [NW-1:0][31:0]  sr32;

  // srl is sra with a zero fill bit
  assign is_sra = (op == ALU_SRA);

  // e8, 3-bit amount
  for (genvar k = 0; k < NB; k++) begin : g_e8
    logic       fill;
    logic [8:0] ext;
    assign fill   = is_sra & a.b[k][7];
    assign ext    = $signed({fill, a.b[k]}) >>> amt.b[k][2:0];
    assign sr8[k] = ext[7:0];
    assign sl8[k] = a.b[k] << amt.b[k][2:0];
  end

  // e16, 4-bit amount
  for (genvar k = 0; k < NH; k++) begin : g_e16
    logic        fill;
    logic [16:0] ext;
    assign fill    = is_sra & a.h[k][15];
    assign ext     = $signed({fill, a.h[k]}) >>> amt.h[k][3:0];
    assign sr16[k] = ext[15:0];
    assign sl16[k] = a.h[k] << amt.h[k][3:0];
  end

  // e32, 5-bit amount
  for (genvar k = 0; k < NW; k++) begin : g_e32
    logic        fill;
    logic [32:0] ext;
    assign fill    = is_sra & a.w[k][31];
    assign ext     = $signed({fill, a.w[k]}) >>> amt.w[k][4:0];
    assign sr32[k] = ext[31:0];
    assign sl32[k] = a.w[k] << amt.w[k][4:0];
  end

  // pick width view, then direction
  always_comb begin
    case (sew)
      SEW_16:  res.h = (op == ALU_SLL) ? sl16 : sr16;
      SEW_32:  res.w = (op == ALU_SLL) ? sl32 : sr32;
      default: res.b = (op == ALU_SLL) ? sl8 : sr8;
    endcase
  end

endmodule

/* source/vec_alu_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One combinational ALU lane, zero latency.
// Result valid follows uop valid in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vec_alu_unit
  import vec_alu_pkg::*;
(
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        result_valid,
  output alu_result_t result
);

  // opcode class
  logic  is_sub;
  logic  is_addsub;
  logic  is_shift;

  // sub-unit outputs
  vreg_u addsub_res;
  vreg_u shift_res;
  vreg_u logic_res;

  // decode
  assign is_sub    = (uop.op == ALU_SUB);
  assign is_addsub = (uop.op == ALU_ADD) || is_sub;
  assign is_shift  = (uop.op == ALU_SLL) || (uop.op == ALU_SRL) || (uop.op == ALU_SRA);

  vec_alu_addsub u_addsub (
    .is_sub (is_sub),
    .sew    (uop.sew),
    .a      (uop.vs2),
    .b      (uop.vs1),
    .sum    (addsub_res)
  );

  // vs2 is the shifted value, vs1 the amount
  vec_alu_shift u_shift (
    .op     (uop.op),
    .sew    (uop.sew),
    .a      (uop.vs2),
    .amt    (uop.vs1),
    .res    (shift_res)
  );

  // bitwise ops ignore sew
  always_comb begin
    case (uop.op)
      ALU_AND: logic_res = uop.vs2 & uop.vs1;
      ALU_OR:  logic_res = uop.vs2 | uop.vs1;
      default: logic_res = uop.vs2 ^ uop.vs1;
    endcase
  end

  // result mux by class
  always_comb begin
    result.tag = uop.tag;
    if (is_addsub) begin
      result.data = addsub_res;
    end else if (is_shift) begin
      result.data = shift_res;
    end else begin
      result.data = logic_res;
    end
  end

  assign result_valid = uop_valid;

  // station must only hold decodable uops
  always_comb begin
    if (uop_valid) begin
      a_legal_uop : assert final (!$isunknown(uop.op) &&
                                  (uop.sew inside {SEW_8, SEW_16, SEW_32}))
        else $error("illegal opcode or sew on valid uop");
    end
  end

endmodule

/* source/vec_alu_issue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane valid from station occupancy and all-or-nothing pop.
// Nothing pops unless every valid lane has ROB ready.
// clk and rst serve only the checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_issue (
  input  logic                clk,
  input  logic                rst,
  input  logic                rs_empty,
  input  logic [`NUM_ALU-1:1] rs_almost_empty,
  input  logic [`NUM_ALU-1:0] lane_result_valid,
  input  logic [`NUM_ALU-1:0] rob_ready,
  output logic [`NUM_ALU-1:0] lane_valid,
  output logic [`NUM_ALU-1:0] pop
);

  logic pop_fire;

  // lane 0 needs one entry
  assign lane_valid[0] = !rs_empty;

  // lane i needs at least i+1 entries
  for (genvar i = 1; i < `NUM_ALU; i++) begin : g_valid
    assign lane_valid[i] = !(rs_empty || (|rs_almost_empty[i:1]));
  end

  // every valid lane done and accepted
  assign pop_fire = (lane_valid == lane_result_valid) &&
                    ((lane_valid & ~rob_ready) == '0);

  // pop the whole valid run or nothing
  assign pop = pop_fire ? lane_valid : '0;

  // a stalled lane keeps its entry until it pops
  a_valid_hold : assert property (@(posedge clk) disable iff (rst)
    ((|lane_valid) && !(|pop)) |=>
      ((lane_valid & $past(lane_valid)) == $past(lane_valid)))
    else $error("lane_valid dropped while stalled");

endmodule

/* source/vec_alu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Station, issue and lanes. result_valid is the pop vector.
// Push only while full is low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_top
  import vec_alu_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          push,
  input  alu_uop_t                      push_uop,
  output logic                          full,
  output logic        [`NUM_ALU-1:0]    result_valid,
  output alu_result_t [`NUM_ALU-1:0]    result,
  input  logic        [`NUM_ALU-1:0]    rob_ready
);

  // station to issue and lanes
  logic                       rs_empty;
  logic     [`NUM_ALU-1:1]    rs_almost_empty;
  alu_uop_t [`NUM_ALU-1:0]    lane_uop;
  // issue to lanes and back
  logic     [`NUM_ALU-1:0]    lane_valid;
  logic     [`NUM_ALU-1:0]    lane_result_valid;
  logic     [`NUM_ALU-1:0]    pop;

  vec_alu_rs u_rs (
    .clk             (clk),
    .rst             (rst),
    .push            (push),
    .push_uop        (push_uop),
    .pop             (pop),
    .full            (full),
    .rs_empty        (rs_empty),
    .rs_almost_empty (rs_almost_empty),
    .lane_uop        (lane_uop)
  );

  vec_alu_issue u_issue (
    .clk               (clk),
    .rst               (rst),
    .rs_empty          (rs_empty),
    .rs_almost_empty   (rs_almost_empty),
    .lane_result_valid (lane_result_valid),
    .rob_ready         (rob_ready),
    .lane_valid        (lane_valid),
    .pop               (pop)
  );

  for (genvar i = 0; i < `NUM_ALU; i++) begin : g_lane
    vec_alu_unit u_unit (
      .uop_valid    (lane_valid[i]),
      .uop          (lane_uop[i]),
      .result_valid (lane_result_valid[i]),
      .result       (result[i])
    );
  end

  // results leave exactly when entries retire
  assign result_valid = pop;

endmodule

/* dv/vec_alu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Plays dispatch and ROB. The model updates on negedge and
// DUT outputs are checked at posedge by assertions.
// Pushes are gated so the station is never pushed while full.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "vec_alu_params.svh"

module vec_alu_tb
  import vec_alu_pkg::*;
();

  localparam int N = `NUM_ALU;

  logic                  clk;
  logic                  rst;
  logic                  push;
  alu_uop_t              push_uop;
  logic                  full;
  logic        [N-1:0]   result_valid;
  alu_result_t [N-1:0]   result;
  logic        [N-1:0]   rob_ready;

  // reference model state with the oldest entry at q[0]
  alu_uop_t              q[$];
  logic        [N-1:0]   exp_lv;
  logic        [N-1:0]   exp_rv;
  alu_result_t [N-1:0]   exp_res;
  logic                  exp_full;
  logic                  pend_push;
  alu_uop_t              pend_uop;
  int                    pend_pop;
  // occupancy after the coming edge
  int                    occ_next;
  int                    accepted_cnt;
  int                    seen_cnt;
  int                    err_cnt;
  int                    phase_err;
  int                    phases_ok;
  int                    phases_bad;
  logic [`ROB_TAG_W-1:0] tag_ctr;

  vec_alu_top u_vec_alu_top (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_uop     (push_uop),
    .full         (full),
    .result_valid (result_valid),
    .result       (result),
    .rob_ready    (rob_ready)
  );

  always #50 clk = ~clk;

  // element-wise result of vd = vs2 op vs1
  function automatic alu_result_t ref_alu(alu_uop_t u);
    alu_result_t      r;
    logic [`VLEN-1:0] acc;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      y;
    logic [31:0]      msk;
    int               ew;
    int               sh;
    ew  = 8 << u.sew;
    msk = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 1);
    acc = '0;
    for (int e = 0; e < `VLEN / ew; e++) begin
      a  = 32'(u.vs2 >> (e * ew)) & msk;
      b  = 32'(u.vs1 >> (e * ew)) & msk;
      // amount is b modulo the element width
      sh = int'(b % ew);
      case (u.op)
        ALU_ADD: y = a + b;
        ALU_SUB: y = a - b;
        ALU_SLL: y = a << sh;
        ALU_SRL: y = a >> sh;
        // vacated high bits take the element sign
        ALU_SRA: y = (a >> sh) | (a[ew-1] ? (msk & ~(msk >> sh)) : 32'd0);
        ALU_AND: y = a & b;
        ALU_OR:  y = a | b;
        default: y = a ^ b;
      endcase
      // upper carry dropped by the mask
      acc = acc | ({{(`VLEN - 32){1'b0}}, y & msk} << (e * ew));
    end
    r.tag  = u.tag;
    r.data = acc;
    return r;
  endfunction

  function automatic alu_uop_t rand_uop();
    alu_uop_t u;
    u.tag = '0;
    u.op  = alu_op_e'($urandom_range(7, 0));
    u.sew = sew_e'($urandom_range(2, 0));
    for (int k = 0; k < `VLEN / 32; k++) begin
      u.vs2.w[k] = $urandom;
      u.vs1.w[k] = $urandom;
    end
    return u;
  endfunction

  // carry, borrow and sign-fill corners with sew from idx % 3
  function automatic alu_uop_t corner_uop(int idx);
    alu_uop_t u;
    u     = rand_uop();
    u.sew = sew_e'(idx % 3);
    u.vs1 = {(`VLEN / 8){8'h01}};
    case (idx / 3)
      0: begin
        u.op  = ALU_ADD;
        u.vs2 = '1;
      end
      1: begin
        u.op  = ALU_SUB;
        u.vs2 = '0;
      end
      2: u.op = ALU_SRA;
      3: u.op = ALU_SRL;
      default: u.op = ALU_SLL;
    endcase
    // msb set in bytes, halves and words
    if (idx / 3 >= 2) begin
      u.vs2 = {(`VLEN / 32){32'h8000_8081}};
      u.vs1 = {(`VLEN / 8){8'h03}};
    end
    return u;
  endfunction

  // apply the last edge and set expectations for the next
  always @(negedge clk) begin
    if (rst) begin
      q.delete();
    end else begin
      repeat (pend_pop)
        void'(q.pop_front());
      if (pend_push) begin
        q.push_back(pend_uop);
        accepted_cnt++;
      end
      seen_cnt += $countones(result_valid);
    end
    exp_full = (q.size() == `RS_DEPTH);
    for (int i = 0; i < N; i++) begin
      exp_lv[i]  = (q.size() > i);
      exp_res[i] = '0;
      if (exp_lv[i]) begin
        exp_res[i] = ref_alu(q[i]);
      end
    end
    // all-or-nothing retire
    exp_rv    = ((exp_lv & ~rob_ready) == '0) ? exp_lv : '0;
    pend_pop  = rst ? 0 : $countones(exp_rv);
    pend_push = !rst && push && !exp_full;
    pend_uop  = push_uop;
    occ_next  = q.size() + int'(pend_push) - pend_pop;
  end

  a_rv_match : assert property (@(posedge clk) disable iff (rst) result_valid == exp_rv)
    else begin
      err_cnt++;
      $display("ERROR @%0t: result_valid %b, expected %b", $time,
               $sampled(result_valid), $sampled(exp_rv));
    end

  a_full_match : assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else begin
      err_cnt++;
      $display("ERROR @%0t: full %b, expected %b", $time, $sampled(full), $sampled(exp_full));
    end

  for (genvar i = 0; i < N; i++) begin : g_lane_chk
    // tag and data of every occupied lane
    a_data : assert property (@(posedge clk) disable iff (rst)
      exp_lv[i] |-> (result[i] == exp_res[i]))
      else begin
        err_cnt++;
        $display("ERROR @%0t: lane %0d result %h, expected %h", $time, i,
                 $sampled(result[i]), $sampled(exp_res[i]));
      end

    // stalled lane keeps its result
    a_hold : assert property (@(posedge clk) disable iff (rst)
      (exp_lv[i] && (result_valid == '0)) |=> $stable(result[i]))
      else begin
        err_cnt++;
        $display("ERROR @%0t: lane %0d result changed while stalled", $time, i);
      end
  end

  task automatic step(input logic want_push, input alu_uop_t u, input logic [N-1:0] rdy);
    logic pushed;
    @(posedge clk);
    pushed     = want_push && (occ_next < `RS_DEPTH);
    u.tag      = tag_ctr;
    push      <= pushed;
    push_uop  <= u;
    rob_ready <= rdy;
    if (pushed) begin
      tag_ctr++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (occ_next != 0 && n < limit) begin
      step(1'b0, '0, '1);
      n++;
    end
    if (occ_next != 0) begin
      abort_on_timeout("station did not drain in time");
    end
  endtask

  task automatic start_phase();
    phase_err = err_cnt;
  endtask

  task automatic end_phase(input string name);
    if (err_cnt == phase_err) begin
      phases_ok++;
      $display("phase %s: pass", name);
    end else begin
      phases_bad++;
      $display("phase %s: fail, %0d errors", name, err_cnt - phase_err);
    end
  endtask

  initial begin
    int n;
    void'($urandom(97024));
    clk          = 1'b0;
    rst          = 1'b1;
    push         = 1'b0;
    push_uop     = '0;
    rob_ready    = '0;
    tag_ctr      = '0;
    pend_push    = 1'b0;
    pend_pop     = 0;
    occ_next     = 0;
    accepted_cnt = 0;
    seen_cnt     = 0;
    err_cnt      = 0;
    phases_ok    = 0;
    phases_bad   = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // nothing valid and nothing full
    start_phase();
    repeat (4) step(1'b0, '0, '1);
    end_phase("idle after reset");

    // one entry at a time on lane 0 only
    start_phase();
    for (int c = 0; c < 15; c++) begin
      step(1'b1, corner_uop(c), '1);
      step(1'b0, '0, '1);
      wait_drain(10);
    end
    end_phase("directed ops, single entry");

    // random ready with both lanes retiring together when allowed
    start_phase();
    for (int c = 0; c < 150; c++) begin
      step($urandom_range(1, 0) == 1, rand_uop(), N'($urandom));
    end
    wait_drain(40);
    end_phase("random ops with back-pressure");

    // fill the station behind a stalled ROB
    start_phase();
    n = 0;
    while (occ_next < `RS_DEPTH && n < 4 * `RS_DEPTH) begin
      step(1'b1, rand_uop(), '0);
      n++;
    end
    if (occ_next < `RS_DEPTH) begin
      abort_on_timeout("station never reached full");
    end
    repeat (4) step(1'b1, rand_uop(), '0);
    wait_drain(40);
    repeat (2) step(1'b0, '0, '1);
    a_count : assert (seen_cnt == accepted_cnt)
      else begin
        err_cnt++;
        $display("ERROR @%0t: %0d results seen for %0d accepted pushes", $time,
                 seen_cnt, accepted_cnt);
      end
    end_phase("full station and result count");

    $display("phases passed %0d, failed %0d", phases_ok, phases_bad);
    if (phases_bad == 0 && err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vec_alu_top.f */
+incdir+source
source/vec_alu_pkg.sv
source/vec_alu_rs.sv
source/vec_alu_addsub.sv
source/vec_alu_shift.sv
source/vec_alu_unit.sv
source/vec_alu_issue.sv
source/vec_alu_top.sv
dv/vec_alu_tb.sv

/* Bender.yml */
package:
  name: vec_alu

export_include_dirs:
  - source

sources:
  - files:
      - source/vec_alu_pkg.sv
      - source/vec_alu_rs.sv
      - source/vec_alu_addsub.sv
      - source/vec_alu_shift.sv
      - source/vec_alu_unit.sv
      - source/vec_alu_issue.sv
      - source/vec_alu_top.sv
  - target: test
    files:
      - dv/vec_alu_tb.sv
